// File: vlog.f
cpu_isa_pkg.sv
cpu_bus_pkg.sv
alu.sv
decoder.sv
register_file.sv
inst_mem.sv
bootloader.sv
core_pipeline.sv
cpu_top.sv
tb_cpu_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu_top -f vlog.f

result=$(./obj_dir/Vtb_cpu_top || true)
echo "$result"

# Exit status follows the search for the pass line
echo "$result" | grep -qx "Test passed"

// File: tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;
	import cpu_isa_pkg::*;

	localparam int PROG_WORDS = 64;

	logic clk;
	logic rst_n = 1'b0;
	logic flash_ready = 1'b0;
	word_t flash_data = '0;
	word_t flash_addr;
	logic flash_rd;
	logic boot_done;
	logic halted;
	reg_write_t wb;

	logic [31:0] lcg_state = 32'h5238_8c76;
	word_t prog [PROG_WORDS];
	reg_addr_t exp_addr [$];
	word_t exp_val [$];
	int model_count;
	int limit;
	int cycles;
	int read_count;
	int wr_count;

	// Flash model state
	logic busy = 1'b0;
	int wait_left;
	word_t req_addr;
	logic rd_seen;
	logic ready_seen;
	logic rst_seen;
	word_t addr_seen;

	cpu_top #(
		.PROG_WORDS(PROG_WORDS),
		.MEM_AW(8)
	) DUT (
		.clk(clk),
		.rst_n(rst_n),
		.flash_addr(flash_addr),
		.flash_rd(flash_rd),
		.flash_ready(flash_ready),
		.flash_data(flash_data),
		.boot_done(boot_done),
		.halted(halted),
		.wb(wb)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic value_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state >> 16;
	endfunction

	// Random ALU instruction that may be an LI if allowed
	function automatic word_t rand_op(input reg_addr_t rd, input reg_addr_t rs,
		input logic allow_li);
		logic [31:0] r;
		reg_addr_t rt;
		int sel;
		r = lcg_next();
		rt = reg_addr_t'(r[15:8] % 8'd6);
		sel = allow_li ? int'(r[7:0] % 8'd6) : 1 + int'(r[7:0] % 8'd5);
		case (sel)
			0: return {OP_LI, rd, 1'b0, r[15:8]};
			1: return {OP_ADD, rd, rs, rt, 3'b000};
			2: return {OP_SUB, rd, rs, rt, 3'b000};
			3: return {OP_AND, rd, rs, rt, 3'b000};
			4: return {OP_OR, rd, rs, rt, 3'b000};
			default: return {OP_SLL, rd, rs, rt, 3'b000};
		endcase
	endfunction

	// Second instruction reads the first one's result
	task automatic add_pair(inout int n);
		reg_addr_t d;
		d = reg_addr_t'(1 + lcg_next() % 5);
		prog[n] = rand_op(d, reg_addr_t'(lcg_next() % 6), 1'b1);
		prog[n + 1] = rand_op(reg_addr_t'(lcg_next() % 6), d, 1'b0);
		n += 2;
	endtask

	task automatic build_program();
		int n;
		int loop_top;
		logic [31:0] v;
		for (int i = 0; i < PROG_WORDS; i++) begin
			prog[i] = '0;
		end
		n = 0;
		for (int r = 1; r <= 5; r++) begin
			v = lcg_next();
			prog[n] = {OP_LI, reg_addr_t'(r), 1'b0, v[7:0]};
			n++;
		end
		// r5 comes from EXE through rt
		prog[n] = {OP_SUB, 3'd1, 3'd2, 3'd5, 3'b000};
		// Result aimed at r0 must not commit
		prog[n + 1] = {OP_ADD, 3'd0, 3'd1, 3'd1, 3'b000};
		n += 2;
		for (int g = 0; g < 10; g++) begin
			add_pair(n);
		end
		// Loop counter in r7 with its decrement in r6
		v = lcg_next();
		prog[n] = {OP_LI, 3'd7, 1'b0, 8'd3 + 8'(v % 3)};
		prog[n + 1] = {OP_LI, 3'd6, 1'b0, 8'd1};
		n += 2;
		loop_top = n;
		add_pair(n);
		prog[n] = {OP_SUB, 3'd7, 3'd7, 3'd6, 3'b000};
		prog[n + 1] = {OP_BNEZ, 3'd7, 1'b0, 8'(loop_top - (n + 2))};
		prog[n + 2] = {OP_ADD, 3'd5, 3'd5, 3'd1, 3'b000};
		n += 3;
		// Never taken because r6 holds 1
		prog[n] = {OP_BEQZ, 3'd6, 1'b0, 8'd3};
		prog[n + 1] = rand_op(3'd4, 3'd5, 1'b0);
		n += 2;
		for (int g = 0; g < 5; g++) begin
			add_pair(n);
		end
		prog[n] = {OP_HALT, 12'h000};
	endtask

	task automatic run_model();
		word_t regs [8];
		word_t inst;
		word_t a;
		word_t b;
		word_t y;
		opcode_t op;
		int pc;
		int target;
		int jump;
		logic pending;
		logic taken;
		logic writes;
		for (int i = 0; i < 8; i++) begin
			regs[i] = '0;
		end
		pc = 0;
		target = 0;
		pending = 1'b0;
		model_count = 0;
		forever begin
			inst = prog[pc];
			op = opcode_t'(inst[15:12]);
			if (op == OP_HALT) begin
				break;
			end
			model_count++;
			if (model_count > 1000) begin
				abort_run("reference model never reached HALT");
			end
			a = regs[inst[8:6]];
			b = regs[inst[5:3]];
			y = '0;
			writes = 1'b1;
			taken = 1'b0;
			jump = pc + 1 + int'($signed(inst[7:0]));
			case (op)
				OP_LI: y = {{8{inst[7]}}, inst[7:0]};
				OP_ADD: y = a + b;
				OP_SUB: y = a - b;
				OP_AND: y = a & b;
				OP_OR: y = a | b;
				OP_SLL: y = a << b[3:0];
				OP_BNEZ: begin
					writes = 1'b0;
					taken = regs[inst[11:9]] != '0;
				end
				OP_BEQZ: begin
					writes = 1'b0;
					taken = regs[inst[11:9]] == '0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && inst[11:9] != 3'd0) begin
				regs[inst[11:9]] = y;
				exp_addr.push_back(inst[11:9]);
				exp_val.push_back(y);
			end
			// Delay slot runs before the jump
			pc = pending ? target : pc + 1;
			pending = taken;
			target = jump;
		end
	endtask

	// Flash answers 1 to 4 cycles after the read is seen
	always @(posedge clk) begin
		rd_seen = flash_rd;
		ready_seen = flash_ready;
		rst_seen = rst_n;
		addr_seen = flash_addr;
		#1;
		flash_ready = 1'b0;
		if (!rst_seen) begin
			busy = 1'b0;
		end else if (busy) begin
			if (wait_left == 0) begin
				flash_ready = 1'b1;
				flash_data = prog[req_addr[5:0]];
				busy = 1'b0;
			end else begin
				wait_left--;
			end
		end else if (rd_seen && !ready_seen) begin
			assert (addr_seen == word_t'(read_count))
				else value_mismatch($sformatf("flash read of address %0d, expected %0d",
					addr_seen, read_count));
			req_addr = addr_seen;
			read_count++;
			busy = 1'b1;
			wait_left = int'(lcg_next() % 4);
		end
	end

	always @(posedge clk) begin
		if (rst_n && wb.en) begin
			assert (wr_count < exp_addr.size())
				else abort_run("register write after the expected sequence ended");
			assert (wb.addr == exp_addr[wr_count] && wb.value == exp_val[wr_count])
				else value_mismatch($sformatf("write %0d is r%0d=%h, expected r%0d=%h",
					wr_count, wb.addr, wb.value, exp_addr[wr_count], exp_val[wr_count]));
			wr_count++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= limit) begin
			abort_run($sformatf("run timed out after %0d cycles", cycles));
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) flash_rd && !flash_ready |=> flash_rd)
		else abort_run("flash_rd dropped before flash_ready");
	assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> boot_done)
		else abort_run("register write before boot finished");
	assert property (@(posedge clk) disable iff (!rst_n) boot_done |=> boot_done)
		else abort_run("boot_done fell");
	assert property (@(posedge clk) disable iff (!rst_n) wb.en |-> wb.addr != '0)
		else abort_run("register write to r0 committed");
	assert property (@(posedge clk) disable iff (!rst_n) halted |-> !wb.en)
		else abort_run("register write after halt");

	initial begin
		build_program();
		run_model();
		limit = PROG_WORDS * 6 + 4 * model_count + 50;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		while (!halted) begin
			@(posedge clk);
		end
		// Watch a few cycles past the halt
		repeat (5) @(posedge clk);
		if (wr_count == exp_addr.size() && read_count == PROG_WORDS) begin
			$display("Test passed");
			$finish;
		end else begin
			abort_run($sformatf("%0d writes and %0d flash reads, expected %0d and %0d",
				wr_count, read_count, exp_addr.size(), PROG_WORDS));
		end
	end

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int PROG_WORDS = 64,
	parameter int MEM_AW = 8
) (
	input logic clk,
	input logic rst_n,
	output cpu_isa_pkg::word_t flash_addr,
	output logic flash_rd,
	input logic flash_ready,
	input cpu_isa_pkg::word_t flash_data,
	output logic boot_done,
	output logic halted,
	output cpu_isa_pkg::reg_write_t wb
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	imem_write_t imem_wr;
	imem_addr_t fetch_addr;
	word_t fetch_data;
	reg_addr_t rs;
	reg_addr_t rt;
	word_t rs_value;
	word_t rt_value;

	bootloader #(
		.PROG_WORDS(PROG_WORDS),
		.MEM_AW(MEM_AW)
	) __bootloader(
		.clk(clk),
		.rst_n(rst_n),
		.flash_addr(flash_addr),
		.flash_rd(flash_rd),
		.flash_ready(flash_ready),
		.flash_data(flash_data),
		.imem_wr(imem_wr),
		.boot_done(boot_done)
	);

	inst_mem #(
		.MEM_AW(MEM_AW)
	) __inst_mem(
		.clk(clk),
		.wr(imem_wr),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data)
	);

	register_file __register_file(
		.clk(clk),
		.rst_n(rst_n),
		.rs(rs),
		.rt(rt),
		.rs_value(rs_value),
		.rt_value(rt_value),
		.wr(wb)
	);

	core_pipeline __core_pipeline(
		.clk(clk),
		.rst_n(rst_n),
		.boot_done(boot_done),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.rs(rs),
		.rt(rt),
		.rs_value(rs_value),
		.rt_value(rt_value),
		.wb(wb),
		.halted(halted)
	);

endmodule

// File: core_pipeline.sv
`timescale 1ns/1ps

module core_pipeline (
	input logic clk,
	input logic rst_n,
	input logic boot_done,
	output cpu_bus_pkg::imem_addr_t fetch_addr,
	input cpu_isa_pkg::word_t fetch_data,
	output cpu_isa_pkg::reg_addr_t rs,
	output cpu_isa_pkg::reg_addr_t rt,
	input cpu_isa_pkg::word_t rs_value,
	input cpu_isa_pkg::word_t rt_value,
	output cpu_isa_pkg::reg_write_t wb,
	output logic halted
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	word_t pc;
	logic if_id_valid;
	word_t if_id_pc;
	word_t id_inst;
	ctrl_t ctrl;
	word_t rs_fwd;
	word_t rt_fwd;
	word_t op_b;
	word_t target;
	logic take_branch;
	ctrl_t ex_ctrl;
	word_t ex_a;
	word_t ex_b;
	word_t ex_y;

	assign fetch_addr = imem_addr_t'(pc);

	// Invalid fetch slot decodes as NOP
	assign id_inst = if_id_valid ? fetch_data : '0;

	decoder __decoder(
		.inst(id_inst),
		.ctrl(ctrl)
	);

	assign rs = ctrl.rs;
	assign rt = ctrl.rt;

	// Only the EXE result can be newer than the register file
	assign rs_fwd = (wb.en && wb.addr == ctrl.rs) ? wb.value : rs_value;
	assign rt_fwd = (wb.en && wb.addr == ctrl.rt) ? wb.value : rt_value;
	assign op_b = ctrl.use_imm ? ctrl.imm : rt_fwd;

	assign target = if_id_pc + 16'd1 + ctrl.imm;
	assign take_branch = ctrl.is_branch && ((rs_fwd == '0) == ctrl.branch_on_zero);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			if_id_valid <= 1'b0;
			halted <= 1'b0;
			ex_ctrl <= '0;
		end else begin
			// PC already points at the delay slot when a branch is in ID
			if (boot_done && !halted && !ctrl.is_halt) begin
				pc <= take_branch ? target : pc + 16'd1;
				if_id_valid <= 1'b1;
			end else begin
				if_id_valid <= 1'b0;
			end
			if (ctrl.is_halt) begin
				halted <= 1'b1;
			end
			ex_ctrl <= ctrl;
		end
	end

	always_ff @(posedge clk) begin
		if_id_pc <= pc;
		ex_a <= rs_fwd;
		ex_b <= op_b;
	end

	alu __alu(
		.op(ex_ctrl.alu_op),
		.a(ex_a),
		.b(ex_b),
		.y(ex_y)
	);

	assign wb = '{en: ex_ctrl.reg_write, addr: ex_ctrl.rd, value: ex_y};

	assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted);

	// Everything older than HALT has retired by the time it leaves ID
	assert property (@(posedge clk) disable iff (!rst_n) halted |-> !wb.en);

endmodule

// File: bootloader.sv
`timescale 1ns/1ps

module bootloader #(
	parameter int PROG_WORDS = 64,
	parameter int MEM_AW = 8
) (
	input logic clk,
	input logic rst_n,
	output cpu_isa_pkg::word_t flash_addr,
	output logic flash_rd,
	input logic flash_ready,
	input cpu_isa_pkg::word_t flash_data,
	output cpu_bus_pkg::imem_write_t imem_wr,
	output logic boot_done
);
	import cpu_isa_pkg::*;
	import cpu_bus_pkg::*;

	typedef enum logic [1:0] {READ, WRITE, DONE} state_t;

	state_t state;
	logic [MEM_AW-1:0] cnt;
	logic wr_en;
	word_t wr_data;

	assign flash_addr = word_t'(cnt);
	assign imem_wr = '{en: wr_en, addr: imem_addr_t'(cnt), data: wr_data};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= READ;
			cnt <= '0;
			flash_rd <= 1'b0;
			wr_en <= 1'b0;
			boot_done <= 1'b0;
		end else begin
			case (state)
				READ: begin
					if (flash_rd && flash_ready) begin
						flash_rd <= 1'b0;
						wr_en <= 1'b1;
						state <= WRITE;
					end else begin
						flash_rd <= 1'b1;
					end
				end
				WRITE: begin
					wr_en <= 1'b0;
					if (cnt == MEM_AW'(PROG_WORDS - 1)) begin
						boot_done <= 1'b1;
						state <= DONE;
					end else begin
						// Next address goes out with the new read
						cnt <= cnt + 1'b1;
						flash_rd <= 1'b1;
						state <= READ;
					end
				end
				default: ;
			endcase
		end
	end

	// Flash word captured with the ready pulse
	always_ff @(posedge clk) begin
		if (flash_ready) begin
			wr_data <= flash_data;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		flash_rd && !flash_ready |=> flash_rd);

endmodule

// File: inst_mem.sv
`timescale 1ns/1ps

module inst_mem #(
	parameter int MEM_AW = 8
) (
	input logic clk,
	input cpu_bus_pkg::imem_write_t wr,
	input cpu_bus_pkg::imem_addr_t fetch_addr,
	output cpu_isa_pkg::word_t fetch_data
);
	import cpu_isa_pkg::*;

	word_t mem [2**MEM_AW];

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.addr[MEM_AW-1:0]] <= wr.data;
		end
	end

	// Fetch data follows the address by one cycle
	always_ff @(posedge clk) begin
		fetch_data <= mem[fetch_addr[MEM_AW-1:0]];
	end

endmodule

// File: register_file.sv
`timescale 1ns/1ps

module register_file (
	input logic clk,
	input logic rst_n,
	input cpu_isa_pkg::reg_addr_t rs,
	input cpu_isa_pkg::reg_addr_t rt,
	output cpu_isa_pkg::word_t rs_value,
	output cpu_isa_pkg::word_t rt_value,
	input cpu_isa_pkg::reg_write_t wr
);
	import cpu_isa_pkg::*;

	word_t regs [8];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en && wr.addr != '0) begin
			regs[wr.addr] <= wr.value;
		end
	end

	// r0 is hardwired
	assign rs_value = (rs == '0) ? '0 : regs[rs];
	assign rt_value = (rt == '0) ? '0 : regs[rt];

endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
	input cpu_isa_pkg::word_t inst,
	output cpu_isa_pkg::ctrl_t ctrl
);
	import cpu_isa_pkg::*;

	opcode_t op;
	word_t imm_sext;

	assign op = opcode_t'(inst[15:12]);
	assign imm_sext = {{8{inst[7]}}, inst[7:0]};

	always_comb begin
		ctrl = '0;
		case (op)
			OP_LI: begin
				ctrl.alu_op = ALU_PASS;
				ctrl.rd = inst[11:9];
				ctrl.imm = imm_sext;
				ctrl.use_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_SLL: begin
				ctrl.rd = inst[11:9];
				ctrl.rs = inst[8:6];
				ctrl.rt = inst[5:3];
				ctrl.reg_write = 1'b1;
				case (op)
					OP_SUB: ctrl.alu_op = ALU_SUB;
					OP_AND: ctrl.alu_op = ALU_AND;
					OP_OR: ctrl.alu_op = ALU_OR;
					OP_SLL: ctrl.alu_op = ALU_SLL;
					default: ctrl.alu_op = ALU_ADD;
				endcase
			end
			// Branch offset is relative to pc + 1
			OP_BNEZ, OP_BEQZ: begin
				ctrl.rs = inst[11:9];
				ctrl.imm = imm_sext;
				ctrl.is_branch = 1'b1;
				ctrl.branch_on_zero = (op == OP_BEQZ);
			end
			OP_HALT: ctrl.is_halt = 1'b1;
			default: ;
		endcase
		// Writes to r0 are dropped here
		if (ctrl.rd == '0) begin
			ctrl.reg_write = 1'b0;
		end
	end

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
	input cpu_isa_pkg::alu_op_t op,
	input cpu_isa_pkg::word_t a,
	input cpu_isa_pkg::word_t b,
	output cpu_isa_pkg::word_t y
);
	import cpu_isa_pkg::*;

	always_comb begin
		case (op)
			ALU_ADD: y = a + b;
			ALU_SUB: y = a - b;
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			// Shift amount from the low nibble
			ALU_SLL: y = a << b[3:0];
			default: y = b;
		endcase
	end

endmodule

// File: cpu_bus_pkg.sv
package cpu_bus_pkg;

	// Wide enough for MEM_AW up to 8
	typedef logic [7:0] imem_addr_t;

	typedef struct packed {
		logic en;
		imem_addr_t addr;
		cpu_isa_pkg::word_t data;
	} imem_write_t;

endpackage

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_addr_t;

	typedef enum logic [3:0] {
		OP_NOP = 4'h0, OP_LI = 4'h1, OP_ADD = 4'h2, OP_SUB = 4'h3, OP_AND = 4'h4,
		OP_OR = 4'h5, OP_SLL = 4'h6, OP_BNEZ = 4'h7, OP_BEQZ = 4'h8, OP_HALT = 4'h9
	} opcode_t;

	// PASS forwards operand b for LI
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLL, ALU_PASS
	} alu_op_t;

	typedef struct packed {
		alu_op_t alu_op;
		reg_addr_t rd;
		reg_addr_t rs;
		reg_addr_t rt;
		word_t imm;
		logic use_imm;
		logic reg_write;
		logic is_branch;
		logic branch_on_zero;
		logic is_halt;
	} ctrl_t;

	typedef struct packed {
		logic en;
		reg_addr_t addr;
		word_t value;
	} reg_write_t;

endpackage
